// ==== backend_config.svh ====
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// Data word and address width
`define BE_XLEN 32

// Architectural register file
`define BE_NREGS 32
`define BE_RADDR_W 5

`endif

// ==== backend_pkg.sv ====
`include "backend_config.svh"

package backend_pkg;

	typedef logic [`BE_XLEN-1:0] word_t;
	typedef logic [`BE_RADDR_W-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		OR   = 4'd3,
		XOR  = 4'd4,
		SLT  = 4'd5,
		SLTU = 4'd6,
		SLL  = 4'd7,
		SRL  = 4'd8,
		LDW  = 4'd9,
		STW  = 4'd10,
		BEQ  = 4'd11,
		BNE  = 4'd12,
		BLT  = 4'd13,
		NOP  = 4'd15
	} be_op_e;

	// Control part, travels with the stage valid
	typedef struct packed {
		logic      valid;
		be_op_e    op;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		logic      use_imm;
		logic      wr_en;
		logic      predict_taken;
	} ctrl_flow_t;

	typedef struct packed {
		word_t pc;
		word_t imm;
		word_t op_a;
		word_t op_b;
		word_t result;
	} data_flow_t;

	// Decoded instruction as seen on the issue port
	typedef struct packed {
		be_op_e    op;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		logic      use_imm;
		logic      wr_en;
		logic      predict_taken;
		word_t     pc;
		word_t     imm;
	} issue_inst_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic  write;
	} mem_cmd_t;

	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     data;
	} wb_port_t;

	typedef struct packed {
		logic  valid;
		word_t pc;
		logic  taken;
		word_t target;
		logic  mispredict;
	} bpu_update_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     data;
	} fwd_src_t;

endpackage : backend_pkg

// ==== backend_alu.sv ====
`timescale 1ns/100ps

module backend_alu (
	input  backend_pkg::be_op_e op_i,
	input  backend_pkg::word_t  a_i,
	input  backend_pkg::word_t  b_i,
	output backend_pkg::word_t  result_o
);

	localparam int SHAMT_W = $clog2($bits(backend_pkg::word_t));

	logic [SHAMT_W-1:0] shamt;

	assign shamt = b_i[SHAMT_W-1:0];

	always_comb begin
		result_o = '0;
		case (op_i)
			backend_pkg::SUB: begin
				result_o = a_i - b_i;
			end
			backend_pkg::AND: begin
				result_o = a_i & b_i;
			end
			backend_pkg::OR: begin
				result_o = a_i | b_i;
			end
			backend_pkg::XOR: begin
				result_o = a_i ^ b_i;
			end
			backend_pkg::SLT: begin
				result_o[0] = $signed(a_i) < $signed(b_i);
			end
			backend_pkg::SLTU: begin
				result_o[0] = a_i < b_i;
			end
			backend_pkg::SLL: begin
				result_o = a_i << shamt;
			end
			backend_pkg::SRL: begin
				result_o = a_i >> shamt;
			end
			// ADD, and the effective address for LDW and STW
			default: begin
				result_o = a_i + b_i;
			end
		endcase
	end

endmodule : backend_alu

// ==== branch_check.sv ====
`timescale 1ns/100ps

module branch_check (
	input  backend_pkg::ctrl_flow_t  ctrl_i,
	input  backend_pkg::data_flow_t  data_i,
	output backend_pkg::bpu_update_t bpu_update_o
);

	logic is_branch;
	logic taken;

	assign is_branch = ctrl_i.op inside {backend_pkg::BEQ, backend_pkg::BNE, backend_pkg::BLT};

	always_comb begin
		case (ctrl_i.op)
			backend_pkg::BEQ: begin
				taken = data_i.op_a == data_i.op_b;
			end
			backend_pkg::BNE: begin
				taken = data_i.op_a != data_i.op_b;
			end
			backend_pkg::BLT: begin
				taken = $signed(data_i.op_a) < $signed(data_i.op_b);
			end
			default: begin
				taken = 1'b0;
			end
		endcase
	end

	// Target is always pc relative
	always_comb begin
		bpu_update_o.valid      = ctrl_i.valid & is_branch;
		bpu_update_o.pc         = data_i.pc;
		bpu_update_o.taken      = taken;
		bpu_update_o.target     = data_i.pc + data_i.imm;
		bpu_update_o.mispredict = taken != ctrl_i.predict_taken;
	end

endmodule : branch_check

// ==== mem_access_unit.sv ====
`timescale 1ns/100ps

module mem_access_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  backend_pkg::ctrl_flow_t ctrl_i,
	input  backend_pkg::word_t      addr_i,
	input  backend_pkg::word_t      wdata_i,
	output logic                    mem_req_o,
	input  logic                    mem_ack_i,
	output backend_pkg::mem_cmd_t   mem_cmd_o,
	input  backend_pkg::word_t      mem_rdata_i,
	output backend_pkg::word_t      rdata_o,
	output logic                    busy_o
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT_ACK_LOW,
		DONE
	} mau_state_e;

	mau_state_e state;
	logic mem_op;
	backend_pkg::word_t rdata_q;

	assign mem_op = ctrl_i.valid && (ctrl_i.op inside {backend_pkg::LDW, backend_pkg::STW});

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (mem_op) begin
						state <= REQ;
					end
				end
				REQ: begin
					// Ack seen, drop req next cycle
					if (mem_ack_i) begin
						state <= WAIT_ACK_LOW;
					end
				end
				WAIT_ACK_LOW: begin
					if (!mem_ack_i) begin
						state <= DONE;
					end
				end
				// Instruction leaves M2 on this edge
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Read data only valid while ack is high
	always_ff @(posedge clk) begin
		if (state == REQ && mem_ack_i) begin
			rdata_q <= mem_rdata_i;
		end
	end

	assign mem_req_o = state == REQ;
	assign busy_o    = mem_op && state != DONE;
	assign rdata_o   = rdata_q;

	// Command is held stable by the stalled M2 registers
	always_comb begin
		mem_cmd_o.addr  = addr_i;
		mem_cmd_o.wdata = wdata_i;
		mem_cmd_o.write = ctrl_i.op == backend_pkg::STW;
	end

endmodule : mem_access_unit

// ==== pipe_ctrl.sv ====
`timescale 1ns/100ps

module pipe_ctrl (
	input  logic                     issue_i,
	input  backend_pkg::issue_inst_t issue_inst_i,
	input  backend_pkg::ctrl_flow_t  ex_ctrl_i,
	input  backend_pkg::ctrl_flow_t  m1_ctrl_i,
	input  backend_pkg::ctrl_flow_t  m2_ctrl_i,
	input  logic                     mem_busy_i,
	output logic [2:0]               stall_vec_o,
	output logic [2:0]               clr_vec_o,
	output logic                     issue_stall_o
);

	logic uses_rs2;
	logic load_use;

	function automatic logic load_hit(input backend_pkg::ctrl_flow_t c,
			input backend_pkg::issue_inst_t inst, input logic chk_rs2);
		logic is_load;
		is_load = c.valid && c.op == backend_pkg::LDW && c.rd != '0;
		return is_load && (c.rd == inst.rs1 || (chk_rs2 && c.rd == inst.rs2));
	endfunction

	// Stores read rs2 as data even with an immediate
	assign uses_rs2 = !issue_inst_i.use_imm || issue_inst_i.op == backend_pkg::STW;

	assign load_use = load_hit(ex_ctrl_i, issue_inst_i, uses_rs2)
		|| load_hit(m1_ctrl_i, issue_inst_i, uses_rs2)
		|| load_hit(m2_ctrl_i, issue_inst_i, uses_rs2);

	assign stall_vec_o   = {3{mem_busy_i}};
	assign issue_stall_o = mem_busy_i || (issue_i && load_use);

	// Bubble goes into the stage after the highest stalled one
	always_comb begin
		clr_vec_o[2] = stall_vec_o[2];
		for (int i = 0; i < 2; i++) begin
			clr_vec_o[i] = stall_vec_o[i] & ~stall_vec_o[i+1];
		end
	end

endmodule : pipe_ctrl

// ==== operand_read.sv ====
`timescale 1ns/100ps
`include "backend_config.svh"

module operand_read (
	input  logic                         clk,
	input  logic                         rst_n,
	input  backend_pkg::issue_inst_t     issue_inst_i,
	input  backend_pkg::fwd_src_t [3:0]  fwd_i,
	input  backend_pkg::wb_port_t        wb_i,
	output backend_pkg::word_t           op_a_o,
	output backend_pkg::word_t           op_b_o
);

	backend_pkg::word_t regs [`BE_NREGS];
	backend_pkg::word_t rs1_val;
	backend_pkg::word_t rs2_val;

	// Index 0 is EX, the youngest, so it is applied last
	function automatic backend_pkg::word_t read_reg(input backend_pkg::reg_addr_t addr,
			input backend_pkg::word_t file_val, input backend_pkg::fwd_src_t [3:0] fwd);
		backend_pkg::word_t val;
		val = file_val;
		for (int i = 3; i >= 0; i--) begin
			if (fwd[i].valid && fwd[i].rd == addr) begin
				val = fwd[i].data;
			end
		end
		if (addr == '0) begin
			val = '0;
		end
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `BE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.en && wb_i.addr != '0) begin
			regs[wb_i.addr] <= wb_i.data;
		end
	end

	assign rs1_val = read_reg(issue_inst_i.rs1, regs[issue_inst_i.rs1], fwd_i);
	assign rs2_val = read_reg(issue_inst_i.rs2, regs[issue_inst_i.rs2], fwd_i);

	assign op_a_o = rs1_val;
	assign op_b_o = (issue_inst_i.use_imm && issue_inst_i.op != backend_pkg::STW) ?
		issue_inst_i.imm : rs2_val;

endmodule : operand_read

// ==== backend_pipeline.sv ====
`timescale 1ns/100ps

module backend_pipeline (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [2:0]                   stall_vec_i,
	input  logic [2:0]                   clr_vec_i,
	input  logic                         issue_i,
	input  backend_pkg::issue_inst_t     issue_inst_i,
	input  backend_pkg::word_t           op_a_i,
	input  backend_pkg::word_t           op_b_i,
	output backend_pkg::ctrl_flow_t      ex_ctrl_o,
	output backend_pkg::ctrl_flow_t      m1_ctrl_o,
	output backend_pkg::ctrl_flow_t      m2_ctrl_o,
	output logic                         mem_busy_o,
	output backend_pkg::fwd_src_t [3:0]  fwd_o,
	output backend_pkg::wb_port_t        wb_o,
	output backend_pkg::bpu_update_t     bpu_update_o,
	output logic                         mem_req_o,
	input  logic                         mem_ack_i,
	output backend_pkg::mem_cmd_t        mem_cmd_o,
	input  backend_pkg::word_t           mem_rdata_i
);

	backend_pkg::ctrl_flow_t issue_ctrl;
	backend_pkg::ctrl_flow_t ex_ctrl, m1_ctrl, m2_ctrl, wb_ctrl;
	backend_pkg::data_flow_t issue_data;
	backend_pkg::data_flow_t ex_data, ex_data_res, m1_data, m2_data, wb_data;
	backend_pkg::word_t alu_b;
	backend_pkg::word_t alu_result;
	backend_pkg::word_t load_data;
	backend_pkg::bpu_update_t bc_update;
	logic ex_is_mem;
	logic m2_is_load;

	// Loads publish their value only from WB
	function automatic backend_pkg::fwd_src_t alu_fwd(input backend_pkg::ctrl_flow_t c,
			input backend_pkg::word_t d);
		backend_pkg::fwd_src_t f;
		f.valid = c.valid && c.wr_en && c.op != backend_pkg::LDW;
		f.rd    = c.rd;
		f.data  = d;
		return f;
	endfunction

	always_comb begin
		issue_ctrl.valid         = issue_i;
		issue_ctrl.op            = issue_inst_i.op;
		issue_ctrl.rd            = issue_inst_i.rd;
		issue_ctrl.rs1           = issue_inst_i.rs1;
		issue_ctrl.rs2           = issue_inst_i.rs2;
		issue_ctrl.use_imm       = issue_inst_i.use_imm;
		issue_ctrl.wr_en         = issue_inst_i.wr_en;
		issue_ctrl.predict_taken = issue_inst_i.predict_taken;
		issue_data.pc     = issue_inst_i.pc;
		issue_data.imm    = issue_inst_i.imm;
		issue_data.op_a   = op_a_i;
		issue_data.op_b   = op_b_i;
		issue_data.result = '0;
	end

	// Control registers, cleared by reset and by the clear vector
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_ctrl <= '0;
		end else if (!stall_vec_i[0]) begin
			ex_ctrl <= issue_ctrl;
		end
	end
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m1_ctrl <= '0;
		end else if (!stall_vec_i[1]) begin
			m1_ctrl <= clr_vec_i[0] ? '0 : ex_ctrl;
		end
	end
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m2_ctrl <= '0;
		end else if (!stall_vec_i[2]) begin
			m2_ctrl <= clr_vec_i[1] ? '0 : m1_ctrl;
		end
	end
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ctrl <= '0;
		end else begin
			wb_ctrl <= clr_vec_i[2] ? '0 : m2_ctrl;
		end
	end

	// Data registers follow the same stalls
	always_ff @(posedge clk) begin
		if (!stall_vec_i[0]) begin
			ex_data <= issue_data;
		end
		if (!stall_vec_i[1]) begin
			m1_data <= ex_data_res;
		end
		if (!stall_vec_i[2]) begin
			m2_data <= m1_data;
		end
		wb_data        <= m2_data;
		wb_data.result <= m2_is_load ? load_data : m2_data.result;
	end

	// Address generation uses the immediate, op_b stays the store data
	assign ex_is_mem = ex_ctrl.op inside {backend_pkg::LDW, backend_pkg::STW};
	assign alu_b     = ex_is_mem ? ex_data.imm : ex_data.op_b;

	backend_alu i_backend_alu (
		.op_i    (ex_ctrl.op),
		.a_i     (ex_data.op_a),
		.b_i     (alu_b),
		.result_o(alu_result)
	);

	always_comb begin
		ex_data_res        = ex_data;
		ex_data_res.result = alu_result;
	end

	branch_check i_branch_check (
		.ctrl_i      (ex_ctrl),
		.data_i      (ex_data),
		.bpu_update_o(bc_update)
	);

	// Report once, on the cycle the branch leaves EX
	always_comb begin
		bpu_update_o       = bc_update;
		bpu_update_o.valid = bc_update.valid & ~stall_vec_i[0];
	end

	assign m2_is_load = m2_ctrl.op == backend_pkg::LDW;

	mem_access_unit i_mem_access_unit (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl_i     (m2_ctrl),
		.addr_i     (m2_data.result),
		.wdata_i    (m2_data.op_b),
		.mem_req_o  (mem_req_o),
		.mem_ack_i  (mem_ack_i),
		.mem_cmd_o  (mem_cmd_o),
		.mem_rdata_i(mem_rdata_i),
		.rdata_o    (load_data),
		.busy_o     (mem_busy_o)
	);

	always_comb begin
		fwd_o[0]       = alu_fwd(ex_ctrl, alu_result);
		fwd_o[1]       = alu_fwd(m1_ctrl, m1_data.result);
		fwd_o[2]       = alu_fwd(m2_ctrl, m2_data.result);
		fwd_o[3].valid = wb_ctrl.valid && wb_ctrl.wr_en;
		fwd_o[3].rd    = wb_ctrl.rd;
		fwd_o[3].data  = wb_data.result;
	end

	always_comb begin
		wb_o.en   = wb_ctrl.valid && wb_ctrl.wr_en;
		wb_o.addr = wb_ctrl.rd;
		wb_o.data = wb_data.result;
	end

	assign ex_ctrl_o = ex_ctrl;
	assign m1_ctrl_o = m1_ctrl;
	assign m2_ctrl_o = m2_ctrl;

endmodule : backend_pipeline

// ==== backend_top.sv ====
`timescale 1ns/100ps

module backend_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     issue_i,
	input  backend_pkg::issue_inst_t issue_inst_i,
	output logic                     issue_stall_o,
	output logic                     mem_req_o,
	input  logic                     mem_ack_i,
	output backend_pkg::mem_cmd_t    mem_cmd_o,
	input  backend_pkg::word_t       mem_rdata_i,
	output backend_pkg::wb_port_t    wb_o,
	output backend_pkg::bpu_update_t bpu_update_o
);

	logic [2:0] stall_vec;
	logic [2:0] clr_vec;
	logic mem_busy;
	logic issue_accept;
	backend_pkg::word_t op_a, op_b;
	backend_pkg::fwd_src_t [3:0] fwd;
	backend_pkg::ctrl_flow_t ex_ctrl, m1_ctrl, m2_ctrl;

	// Interlocked issue turns into a bubble in EX
	assign issue_accept = issue_i & ~issue_stall_o;

	operand_read i_operand_read (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_inst_i(issue_inst_i),
		.fwd_i       (fwd),
		.wb_i        (wb_o),
		.op_a_o      (op_a),
		.op_b_o      (op_b)
	);

	pipe_ctrl i_pipe_ctrl (
		.issue_i      (issue_i),
		.issue_inst_i (issue_inst_i),
		.ex_ctrl_i    (ex_ctrl),
		.m1_ctrl_i    (m1_ctrl),
		.m2_ctrl_i    (m2_ctrl),
		.mem_busy_i   (mem_busy),
		.stall_vec_o  (stall_vec),
		.clr_vec_o    (clr_vec),
		.issue_stall_o(issue_stall_o)
	);

	backend_pipeline i_backend_pipeline (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall_vec_i (stall_vec),
		.clr_vec_i   (clr_vec),
		.issue_i     (issue_accept),
		.issue_inst_i(issue_inst_i),
		.op_a_i      (op_a),
		.op_b_i      (op_b),
		.ex_ctrl_o   (ex_ctrl),
		.m1_ctrl_o   (m1_ctrl),
		.m2_ctrl_o   (m2_ctrl),
		.mem_busy_o  (mem_busy),
		.fwd_o       (fwd),
		.wb_o        (wb_o),
		.bpu_update_o(bpu_update_o),
		.mem_req_o   (mem_req_o),
		.mem_ack_i   (mem_ack_i),
		.mem_cmd_o   (mem_cmd_o),
		.mem_rdata_i (mem_rdata_i)
	);

endmodule : backend_top

// ==== tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD_NS = 8
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
	end

	always begin
		#(PERIOD_NS / 2);
		clk_o = ~clk_o;
	end

endmodule : tb_clock

// ==== tb_backend.sv ====
`timescale 1ns/100ps
`include "backend_config.svh"

module tb_backend;

	localparam int MAX_ACK_DELAY = 5;
	localparam int MAX_ACK_HOLD = 3;
	localparam int MEM_WORDS = 256;
	localparam logic [31:0] SEED = 32'hb0e3be7c;
	localparam backend_pkg::be_op_e ALU_OPS [9] = '{backend_pkg::ADD, backend_pkg::SUB,
		backend_pkg::AND, backend_pkg::OR, backend_pkg::XOR, backend_pkg::SLT,
		backend_pkg::SLTU, backend_pkg::SLL, backend_pkg::SRL};
	localparam backend_pkg::be_op_e BR_OPS [3] = '{backend_pkg::BEQ, backend_pkg::BNE,
		backend_pkg::BLT};

	logic clk;
	logic rst_n;
	logic issue_i;
	backend_pkg::issue_inst_t issue_inst_i;
	logic issue_stall_o;
	logic mem_req_o;
	logic mem_ack_i;
	backend_pkg::mem_cmd_t mem_cmd_o;
	backend_pkg::word_t mem_rdata_i;
	backend_pkg::wb_port_t wb_o;
	backend_pkg::bpu_update_t bpu_update_o;

	// Memory behind the port and the model's own copy
	backend_pkg::word_t mem [MEM_WORDS];
	backend_pkg::word_t model_mem [MEM_WORDS];
	backend_pkg::word_t model_regs [`BE_NREGS];
	backend_pkg::wb_port_t wb_q [$];
	backend_pkg::bpu_update_t bpu_q [$];

	string cur_test = "init";
	backend_pkg::word_t next_pc = 32'h0000_1000;
	int n_issued = 0;
	int n_mem = 0;
	int cycles = 0;
	int err_wb = 0;
	int err_bpu = 0;
	int err_word = 0;
	int err_other = 0;
	logic stall_seen = 1'b0;

	tb_clock #(.PERIOD_NS(8)) i_tb_clock (.clk_o(clk));

	backend_top i_backend_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue_i      (issue_i),
		.issue_inst_i (issue_inst_i),
		.issue_stall_o(issue_stall_o),
		.mem_req_o    (mem_req_o),
		.mem_ack_i    (mem_ack_i),
		.mem_cmd_o    (mem_cmd_o),
		.mem_rdata_i  (mem_rdata_i),
		.wb_o         (wb_o),
		.bpu_update_o (bpu_update_o)
	);

	function automatic backend_pkg::word_t fill_word(input int idx);
		backend_pkg::word_t addr;
		addr = backend_pkg::word_t'(idx) << 2;
		return (addr * 32'h9e3779b9) ^ 32'h5a5aa5a5;
	endfunction

	function automatic backend_pkg::issue_inst_t make_inst(input backend_pkg::be_op_e op,
			input int rd, input int rs1, input int rs2, input logic use_imm,
			input backend_pkg::word_t imm);
		backend_pkg::issue_inst_t inst;
		inst.op            = op;
		inst.rd            = backend_pkg::reg_addr_t'(rd);
		inst.rs1           = backend_pkg::reg_addr_t'(rs1);
		inst.rs2           = backend_pkg::reg_addr_t'(rs2);
		inst.use_imm       = use_imm;
		inst.wr_en         = !(op inside {backend_pkg::STW, backend_pkg::BEQ, backend_pkg::BNE,
			backend_pkg::BLT, backend_pkg::NOP});
		inst.predict_taken = 1'b0;
		inst.pc            = '0;
		inst.imm           = imm;
		return inst;
	endfunction

	task automatic check_wb(input string name, input backend_pkg::wb_port_t exp,
			input backend_pkg::wb_port_t act);
		if (act !== exp) begin
			err_wb++;
			$display("ERR %s wb expected en=%0b x%0d=%h actual en=%0b x%0d=%h", name,
				exp.en, exp.addr, exp.data, act.en, act.addr, act.data);
		end
	endtask

	task automatic check_bpu(input string name, input backend_pkg::bpu_update_t exp,
			input backend_pkg::bpu_update_t act);
		if (act !== exp) begin
			err_bpu++;
			$display("ERR %s bpu exp pc=%h tk=%0b tgt=%h mis=%0b act pc=%h tk=%0b tgt=%h mis=%0b",
				name, exp.pc, exp.taken, exp.target, exp.mispredict,
				act.pc, act.taken, act.target, act.mispredict);
		end
	endtask

	task automatic check_word(input string name, input backend_pkg::word_t exp,
			input backend_pkg::word_t act);
		if (act !== exp) begin
			err_word++;
			$display("ERR %s word expected %h actual %h", name, exp, act);
		end
	endtask

	// Reference model run in program order at issue time
	task automatic model_step(input backend_pkg::issue_inst_t inst);
		backend_pkg::word_t a;
		backend_pkg::word_t b;
		backend_pkg::word_t res;
		backend_pkg::bpu_update_t upd;
		logic [7:0] idx;
		logic taken;
		a = model_regs[inst.rs1];
		b = model_regs[inst.rs2];
		if (inst.use_imm && inst.op != backend_pkg::STW)
			b = inst.imm;
		idx = 8'((a + inst.imm) >> 2);
		res = '0;
		case (inst.op)
			backend_pkg::ADD:  res = a + b;
			backend_pkg::SUB:  res = a - b;
			backend_pkg::AND:  res = a & b;
			backend_pkg::OR:   res = a | b;
			backend_pkg::XOR:  res = a ^ b;
			backend_pkg::SLT:  res = {31'b0, $signed(a) < $signed(b)};
			backend_pkg::SLTU: res = {31'b0, a < b};
			backend_pkg::SLL:  res = a << b[4:0];
			backend_pkg::SRL:  res = a >> b[4:0];
			backend_pkg::LDW:  res = model_mem[idx];
			backend_pkg::STW:  model_mem[idx] = b;
			backend_pkg::BEQ, backend_pkg::BNE, backend_pkg::BLT: begin
				if (inst.op == backend_pkg::BEQ)
					taken = a == b;
				else if (inst.op == backend_pkg::BNE)
					taken = a != b;
				else
					taken = $signed(a) < $signed(b);
				upd.valid      = 1'b1;
				upd.pc         = inst.pc;
				upd.taken      = taken;
				upd.target     = inst.pc + inst.imm;
				upd.mispredict = taken != inst.predict_taken;
				bpu_q.push_back(upd);
			end
			default: res = '0;
		endcase
		if (inst.wr_en) begin
			wb_q.push_back('{en: 1'b1, addr: inst.rd, data: res});
			if (inst.rd != '0)
				model_regs[inst.rd] = res;
		end
	endtask

	// Called on a falling edge and returns on the falling edge after acceptance
	task automatic issue_inst(input backend_pkg::issue_inst_t inst);
		logic stalled;
		logic first_cycle;
		inst.pc = next_pc;
		next_pc += 4;
		model_step(inst);
		n_issued++;
		if (inst.op inside {backend_pkg::LDW, backend_pkg::STW})
			n_mem++;
		issue_i      = 1'b1;
		issue_inst_i = inst;
		first_cycle  = 1'b1;
		do begin
			// Issue stall has settled well before the next rising edge
			#1;
			stalled = issue_stall_o;
			// Only a stall on the first cycle offered counts since later ones can be memory waits
			if (stalled && first_cycle)
				stall_seen = 1'b1;
			first_cycle = 1'b0;
			@(negedge clk);
		end while (stalled);
		issue_i = 1'b0;
	endtask

	// A marker write leaves WB only after everything older has finished
	task automatic drain_pipe();
		issue_inst(make_inst(backend_pkg::ADD, 31, 0, 0, 1'b1, next_pc));
		do begin
			@(posedge clk);
		end while (wb_q.size() != 0 || bpu_q.size() != 0);
		@(negedge clk);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic run_alu_ops();
		int rd;
		cur_test = "alu_ops";
		for (int r = 1; r <= 8; r++) begin
			issue_inst(make_inst(backend_pkg::ADD, r, 0, 0, 1'b1, $urandom()));
		end
		rd = 10;
		for (int i = 0; i < 9; i++) begin
			issue_inst(make_inst(ALU_OPS[i], rd, $urandom_range(8, 1), $urandom_range(8, 1),
				1'b0, '0));
			issue_inst(make_inst(ALU_OPS[i], rd + 1, $urandom_range(8, 1), 0, 1'b1, $urandom()));
			rd += 2;
		end
		drain_pipe();
	endtask

	task automatic chain_forwarding();
		cur_test = "forwarding";
		stall_seen = 1'b0;
		for (int d = 1; d <= 4; d++) begin
			issue_inst(make_inst(backend_pkg::ADD, 20, 20, 0, 1'b1, $urandom()));
			// Fillers put the consumer d slots behind the producer
			for (int k = 1; k < d; k++) begin
				issue_inst(make_inst(backend_pkg::XOR, 23 + k, k, 0, 1'b1, $urandom()));
			end
			issue_inst(make_inst(backend_pkg::SUB, 21, 4, 20, 1'b0, '0));
			issue_inst(make_inst(backend_pkg::AND, 22, 21, 20, 1'b0, '0));
		end
		if (stall_seen) begin
			err_other++;
			$display("%s: issue stalled during a chain of ALU instructions", cur_test);
		end
		drain_pipe();
	endtask

	task automatic store_load_cycle();
		cur_test = "load_store";
		issue_inst(make_inst(backend_pkg::ADD, 5, 0, 0, 1'b1, 32'h100));
		for (int i = 0; i < 8; i++) begin
			issue_inst(make_inst(backend_pkg::STW, 0, 5, i + 1, 1'b1, 4 * i));
		end
		for (int i = 7; i >= 0; i--) begin
			issue_inst(make_inst(backend_pkg::LDW, 10 + i, 5, 0, 1'b1, 4 * i));
		end
		issue_inst(make_inst(backend_pkg::STW, 0, 5, 3, 1'b1, 32'h20));
		issue_inst(make_inst(backend_pkg::LDW, 18, 5, 0, 1'b1, 32'h20));
		// Never written so it returns the fill pattern
		issue_inst(make_inst(backend_pkg::LDW, 19, 0, 0, 1'b1, 32'h200));
		drain_pipe();
		for (int i = 64; i <= 72; i++) begin
			check_word(cur_test, model_mem[i], mem[i]);
		end
	endtask

	task automatic load_use_interlock();
		cur_test = "load_use";
		stall_seen = 1'b0;
		issue_inst(make_inst(backend_pkg::LDW, 12, 5, 0, 1'b1, 32'h4));
		issue_inst(make_inst(backend_pkg::ADD, 13, 12, 0, 1'b1, 32'h1));
		issue_inst(make_inst(backend_pkg::LDW, 14, 5, 0, 1'b1, 32'h8));
		issue_inst(make_inst(backend_pkg::SUB, 15, 1, 14, 1'b0, '0));
		issue_inst(make_inst(backend_pkg::LDW, 16, 5, 0, 1'b1, 32'hc));
		issue_inst(make_inst(backend_pkg::STW, 0, 5, 16, 1'b1, 32'h10));
		issue_inst(make_inst(backend_pkg::LDW, 17, 5, 0, 1'b1, 32'h10));
		issue_inst(make_inst(backend_pkg::XOR, 18, 17, 16, 1'b0, '0));
		if (!stall_seen) begin
			err_other++;
			$display("%s: issue_stall_o never rose behind a load", cur_test);
		end
		drain_pipe();
		check_word(cur_test, model_mem[68], mem[68]);
	endtask

	task automatic branch_reports();
		backend_pkg::issue_inst_t inst;
		backend_pkg::word_t off;
		int rs1;
		int rs2;
		cur_test = "branches";
		issue_inst(make_inst(backend_pkg::ADD, 26, 0, 0, 1'b1, 32'hffff_fffb));
		issue_inst(make_inst(backend_pkg::ADD, 27, 0, 0, 1'b1, 32'h7));
		for (int o = 0; o < 3; o++) begin
			for (int t = 0; t < 2; t++) begin
				for (int p = 0; p < 2; p++) begin
					if (BR_OPS[o] == backend_pkg::BLT) begin
						rs1 = t == 1 ? 26 : 27;
						rs2 = t == 1 ? 27 : 26;
					end else begin
						rs1 = 1;
						rs2 = ((BR_OPS[o] == backend_pkg::BEQ) == (t == 1)) ? 1 : 2;
					end
					off = ($urandom() & 32'h0000_0ffc) - 32'h800;
					inst = make_inst(BR_OPS[o], 0, rs1, rs2, 1'b0, off);
					inst.predict_taken = p[0];
					issue_inst(inst);
				end
			end
		end
		drain_pipe();
	endtask

	task automatic reset_idle();
		cur_test = "reset";
		// Load waiting in M2 with two ALU results behind it when reset hits
		issue_inst(make_inst(backend_pkg::LDW, 9, 0, 0, 1'b1, 32'h40));
		issue_inst(make_inst(backend_pkg::ADD, 7, 0, 0, 1'b1, 32'h77));
		issue_inst(make_inst(backend_pkg::ADD, 8, 0, 0, 1'b1, 32'h88));
		apply_reset();
		// Work caught by the reset never completes
		wb_q.delete();
		bpu_q.delete();
		foreach (model_regs[i])
			model_regs[i] = '0;
		repeat (10) begin
			@(negedge clk);
			if (wb_o.en || mem_req_o || bpu_update_o.valid || issue_stall_o) begin
				err_other++;
				$display("%s: an output is active after reset with nothing issued", cur_test);
			end
		end
		// Write to x0 must not show up when x0 is read right after
		issue_inst(make_inst(backend_pkg::ADD, 0, 0, 0, 1'b1, 32'h55));
		issue_inst(make_inst(backend_pkg::ADD, 6, 0, 0, 1'b0, '0));
		drain_pipe();
	endtask

	// Memory slave with random ack delay and hold
	initial begin : responder
		logic [7:0] idx;
		mem_ack_i   = 1'b0;
		mem_rdata_i = '0;
		forever begin
			@(negedge clk);
			if (mem_req_o) begin
				repeat ($urandom_range(MAX_ACK_DELAY)) @(negedge clk);
				idx = mem_cmd_o.addr[9:2];
				if (mem_cmd_o.write)
					mem[idx] = mem_cmd_o.wdata;
				else
					mem_rdata_i = mem[idx];
				mem_ack_i = 1'b1;
				do begin
					@(negedge clk);
				end while (mem_req_o);
				repeat ($urandom_range(MAX_ACK_HOLD)) @(negedge clk);
				mem_ack_i = 1'b0;
			end
		end
	end

	// Writes and branch reports are matched in program order
	always @(negedge clk) begin : monitor
		backend_pkg::wb_port_t exp_wb;
		backend_pkg::bpu_update_t exp_bpu;
		if (rst_n && wb_o.en) begin
			if (wb_q.size() == 0) begin
				err_other++;
				$display("%s: unexpected register write to x%0d", cur_test, wb_o.addr);
			end else begin
				exp_wb = wb_q.pop_front();
				check_wb(cur_test, exp_wb, wb_o);
			end
		end
		if (rst_n && bpu_update_o.valid) begin
			if (bpu_q.size() == 0) begin
				err_other++;
				$display("%s: unexpected branch report at pc %h", cur_test, bpu_update_o.pc);
			end else begin
				exp_bpu = bpu_q.pop_front();
				check_bpu(cur_test, exp_bpu, bpu_update_o);
			end
		end
	end

	// Budget grows with the instructions and memory operations issued
	initial begin : watchdog
		while (cycles <= 100 + 20 * n_issued + 40 * MAX_ACK_DELAY * n_mem) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the DUT made no progress within %0d cycles", cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : main
		void'($urandom(SEED));
		issue_i      = 1'b0;
		issue_inst_i = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i]       = fill_word(i);
			model_mem[i] = fill_word(i);
		end
		foreach (model_regs[i])
			model_regs[i] = '0;
		apply_reset();
		run_alu_ops();
		chain_forwarding();
		store_load_cycle();
		load_use_interlock();
		branch_reports();
		reset_idle();
		$display("Error counts: wb %0d, bpu %0d, word %0d, other %0d",
			err_wb, err_bpu, err_word, err_other);
		if (err_wb + err_bpu + err_word + err_other == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule : tb_backend

// ==== tb.f ====
+incdir+.
backend_pkg.sv
backend_alu.sv
branch_check.sv
mem_access_unit.sv
pipe_ctrl.sv
operand_read.sv
backend_pipeline.sv
backend_top.sv
tb_clock.sv
tb_backend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f tb.f --top-module tb_backend -o tb_backend_sim
./obj_dir/tb_backend_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
